// File: source/kernel_pkg.sv
//**********************************************************************
// Kernel control package.
// Widths, register offsets, control bit positions and the slave FSM
// states shared by the host control block.
//**********************************************************************

`default_nettype none

package kernel_pkg;

  // Bus and memory widths.
  localparam int AXIL_ADDR_W   = 16;
  localparam int REG_ADDR_W    = 12;
  localparam int WORD_W        = 32;
  localparam int STRB_W        = WORD_W / 8;
  localparam int PARAM_INDEX_W = 10;
  localparam int PARAM_WORDS   = 1 << PARAM_INDEX_W;

  typedef logic [AXIL_ADDR_W-1:0]   axil_addr_t;
  typedef logic [REG_ADDR_W-1:0]    reg_addr_t;
  typedef logic [WORD_W-1:0]        word_t;
  typedef logic [STRB_W-1:0]        strb_t;
  typedef logic [PARAM_INDEX_W-1:0] param_index_t;

  // Register byte offsets.
  localparam reg_addr_t REG_CTRL   = 12'h000;
  localparam reg_addr_t REG_GIE    = 12'h004;
  localparam reg_addr_t REG_IER    = 12'h008;
  localparam reg_addr_t REG_ISR    = 12'h00C;
  localparam reg_addr_t PARAM_BASE = 12'h010;

  // Control register bits.
  localparam int CTRL_START_BIT = 0;
  localparam int CTRL_DONE_BIT  = 1;
  localparam int CTRL_IDLE_BIT  = 2;

  localparam logic [1:0] RESP_OKAY = 2'b00;

  typedef enum logic [1:0] {
    SLAVE_IDLE,
    SLAVE_REQUEST,
    SLAVE_RESPOND_WRITE,
    SLAVE_RESPOND_READ
  } slave_state_t;

endpackage

`default_nettype wire

// File: source/ctrl_slave.sv
//**********************************************************************
// AXI-Lite control slave.
// Accepts one host access at a time, turns it into a single register
// request pulse and returns the okay response once the target acks.
//**********************************************************************

`timescale 1ns/1ps
`default_nettype none

module ctrl_slave (
  input  logic                   ap_clk,
  input  logic                   reset,
  input  kernel_pkg::axil_addr_t aw_addr,
  input  logic                   aw_valid,
  output logic                   aw_ready,
  input  kernel_pkg::word_t      w_data,
  input  kernel_pkg::strb_t      w_strb,
  input  logic                   w_valid,
  output logic                   w_ready,
  output logic [1:0]             b_resp,
  output logic                   b_valid,
  input  logic                   b_ready,
  input  kernel_pkg::axil_addr_t ar_addr,
  input  logic                   ar_valid,
  output logic                   ar_ready,
  output kernel_pkg::word_t      r_data,
  output logic [1:0]             r_resp,
  output logic                   r_valid,
  input  logic                   r_ready,
  output logic                   reg_req,
  output logic                   reg_write_en,
  output kernel_pkg::reg_addr_t  reg_addr,
  output kernel_pkg::word_t      reg_wdata,
  output kernel_pkg::strb_t      reg_wstrb,
  input  logic                   regs_ack,
  input  logic                   param_ack,
  input  kernel_pkg::word_t      regs_rdata,
  input  kernel_pkg::word_t      param_rdata
);

  kernel_pkg::slave_state_t state;
  logic                     ack;
  kernel_pkg::word_t        rdata;
  logic                     accept;

  // Targets drive zero when not addressed, so a plain OR merges them.
  assign ack   = regs_ack | param_ack;
  assign rdata = regs_rdata | param_rdata;

  // Handshake cycle of either address channel.
  assign accept = (state == kernel_pkg::SLAVE_IDLE) && (ar_ready || aw_ready);

  assign b_resp = kernel_pkg::RESP_OKAY;
  assign r_resp = kernel_pkg::RESP_OKAY;

  always_ff @(posedge ap_clk) begin
    if (reset) begin
      state    <= kernel_pkg::SLAVE_IDLE;
      aw_ready <= 1'b0;
      w_ready  <= 1'b0;
      ar_ready <= 1'b0;
      b_valid  <= 1'b0;
      r_valid  <= 1'b0;
      reg_req  <= 1'b0;
    end else begin
      reg_req <= 1'b0;
      case (state)
        kernel_pkg::SLAVE_IDLE: begin
          if (ar_ready || aw_ready) begin
            // Handshake taken this cycle.
            ar_ready <= 1'b0;
            aw_ready <= 1'b0;
            w_ready  <= 1'b0;
            reg_req  <= 1'b1;
            state    <= kernel_pkg::SLAVE_REQUEST;
          end else if (ar_valid) begin
            // Reads win over a write arriving together.
            ar_ready <= 1'b1;
          end else if (aw_valid && w_valid) begin
            aw_ready <= 1'b1;
            w_ready  <= 1'b1;
          end
        end
        kernel_pkg::SLAVE_REQUEST: begin
          if (ack) begin
            if (reg_write_en) begin
              b_valid <= 1'b1;
              state   <= kernel_pkg::SLAVE_RESPOND_WRITE;
            end else begin
              r_valid <= 1'b1;
              state   <= kernel_pkg::SLAVE_RESPOND_READ;
            end
          end
        end
        kernel_pkg::SLAVE_RESPOND_WRITE: begin
          if (b_ready) begin
            b_valid <= 1'b0;
            state   <= kernel_pkg::SLAVE_IDLE;
          end
        end
        default: begin
          if (r_ready) begin
            r_valid <= 1'b0;
            state   <= kernel_pkg::SLAVE_IDLE;
          end
        end
      endcase
    end
  end

  // Request payload. Upper address bits alias onto the 4 KB space.
  always_ff @(posedge ap_clk) begin
    if (accept) begin
      reg_write_en <= !ar_ready;
      reg_addr     <= ar_ready ? ar_addr[kernel_pkg::REG_ADDR_W-1:0]
                               : aw_addr[kernel_pkg::REG_ADDR_W-1:0];
      reg_wdata    <= w_data;
      reg_wstrb    <= w_strb;
    end
    if (state == kernel_pkg::SLAVE_REQUEST && ack && !reg_write_en) begin
      r_data <= rdata;
    end
  end

  // A request is a single pulse.
  a_req_pulse: assert property (@(posedge ap_clk) disable iff (reset)
    reg_req |=> !reg_req);

  // The register block and the parameter memory decode disjoint ranges.
  a_ack_onehot: assert property (@(posedge ap_clk) disable iff (reset)
    !(regs_ack && param_ack));

endmodule

`default_nettype wire

// File: source/ctrl_regs.sv
//**********************************************************************
// Kernel run/status registers.
// Holds start, busy, done and the interrupt registers at word offsets
// zero to three, and drives the go/done strobes to the action core.
//**********************************************************************

`timescale 1ns/1ps
`default_nettype none

module ctrl_regs (
  input  logic                  ap_clk,
  input  logic                  reset,
  input  logic                  reg_req,
  input  logic                  reg_write_en,
  input  kernel_pkg::reg_addr_t reg_addr,
  input  kernel_pkg::word_t     reg_wdata,
  input  kernel_pkg::strb_t     reg_wstrb,
  output logic                  regs_ack,
  output kernel_pkg::word_t     regs_rdata,
  output logic                  go_valid,
  input  logic                  go_stop,
  input  logic                  done_valid,
  output logic                  done_stop,
  output logic                  interrupt
);

  kernel_pkg::reg_addr_t word_addr;
  logic                  regs_sel;
  logic                  host_wr;
  logic                  host_rd;
  logic                  lane0_wr;
  logic                  go_xfer;
  logic                  done_xfer;
  logic                  start;
  logic                  busy;
  logic                  done;
  logic                  idle;
  logic                  gie;
  logic                  ier;
  logic                  isr;
  kernel_pkg::word_t     read_word;

  // Word aligned offset; everything below the parameter base is ours.
  assign word_addr = {reg_addr[kernel_pkg::REG_ADDR_W-1:2], 2'b00};
  assign regs_sel  = reg_addr < kernel_pkg::PARAM_BASE;
  assign host_wr   = reg_req && reg_write_en && regs_sel;
  assign host_rd   = reg_req && !reg_write_en && regs_sel;

  // All control bits live in byte lane 0.
  assign lane0_wr = host_wr && reg_wstrb[0];

  assign go_valid  = start;
  assign done_stop = !busy;
  assign go_xfer   = go_valid && !go_stop;
  assign done_xfer = done_valid && !done_stop;
  assign idle      = !busy && !start;

  always_ff @(posedge ap_clk) begin
    if (reset) begin
      start     <= 1'b0;
      busy      <= 1'b0;
      done      <= 1'b0;
      gie       <= 1'b0;
      ier       <= 1'b0;
      isr       <= 1'b0;
      interrupt <= 1'b0;
    end else begin
      // Start is only taken when the kernel is fully idle.
      if (lane0_wr && word_addr == kernel_pkg::REG_CTRL &&
          reg_wdata[kernel_pkg::CTRL_START_BIT] && idle) begin
        start <= 1'b1;
      end
      if (go_xfer) begin
        start <= 1'b0;
        busy  <= 1'b1;
      end

      // Done is clear on read.
      if (host_rd && word_addr == kernel_pkg::REG_CTRL) begin
        done <= 1'b0;
      end

      if (lane0_wr && word_addr == kernel_pkg::REG_GIE) begin
        gie <= reg_wdata[0];
      end
      if (lane0_wr && word_addr == kernel_pkg::REG_IER) begin
        ier <= reg_wdata[0];
      end
      if (lane0_wr && word_addr == kernel_pkg::REG_ISR && reg_wdata[0]) begin
        isr <= !isr;
      end

      // A completing kernel overrides a clear or toggle in the same cycle.
      if (done_xfer) begin
        busy <= 1'b0;
        done <= 1'b1;
        isr  <= 1'b1;
      end

      interrupt <= gie && ier && isr;
    end
  end

  always_comb begin
    read_word = '0;
    case (word_addr)
      kernel_pkg::REG_CTRL: begin
        read_word[kernel_pkg::CTRL_START_BIT] = start;
        read_word[kernel_pkg::CTRL_DONE_BIT]  = done;
        read_word[kernel_pkg::CTRL_IDLE_BIT]  = idle;
      end
      kernel_pkg::REG_GIE: read_word[0] = gie;
      kernel_pkg::REG_IER: read_word[0] = ier;
      kernel_pkg::REG_ISR: read_word[0] = isr;
      default: read_word = '0;
    endcase
  end

  // Ack and data follow the request by one cycle and stay zero when not addressed.
  always_ff @(posedge ap_clk) begin
    if (reset) begin
      regs_ack   <= 1'b0;
      regs_rdata <= '0;
    end else begin
      regs_ack   <= reg_req && regs_sel;
      regs_rdata <= host_rd ? read_word : '0;
    end
  end

  // Start is never accepted while a run is in progress.
  a_go_not_busy: assert property (@(posedge ap_clk) disable iff (reset)
    !(go_valid && busy));

endmodule

`default_nettype wire

// File: source/param_mem.sv
//**********************************************************************
// Parameter memory.
// 1024 word store, host port for word indexes four and up with byte
// strobes, plus a registered read port for the action core.
//**********************************************************************

`timescale 1ns/1ps
`default_nettype none

module param_mem (
  input  logic                     ap_clk,
  input  logic                     reg_req,
  input  logic                     reg_write_en,
  input  kernel_pkg::reg_addr_t    reg_addr,
  input  kernel_pkg::word_t        reg_wdata,
  input  kernel_pkg::strb_t        reg_wstrb,
  output logic                     param_ack,
  output kernel_pkg::word_t        param_rdata,
  input  logic                     rd_en,
  input  kernel_pkg::param_index_t rd_index,
  output kernel_pkg::word_t        rd_data
);

  kernel_pkg::word_t        mem [kernel_pkg::PARAM_WORDS];
  kernel_pkg::param_index_t host_index;
  logic                     param_sel;

  assign host_index = reg_addr[kernel_pkg::REG_ADDR_W-1:2];
  assign param_sel  = reg_addr >= kernel_pkg::PARAM_BASE;

  // Host port. Reads see the word before any write in the same cycle.
  always_ff @(posedge ap_clk) begin
    if (reg_req && reg_write_en && param_sel) begin
      for (int lane = 0; lane < kernel_pkg::STRB_W; lane++) begin
        if (reg_wstrb[lane]) begin
          mem[host_index][8*lane +: 8] <= reg_wdata[8*lane +: 8];
        end
      end
    end
  end

  always_ff @(posedge ap_clk) begin
    param_ack   <= reg_req && param_sel;
    param_rdata <= (reg_req && !reg_write_en && param_sel) ? mem[host_index] : '0;
  end

  // Kernel port holds its last word while idle
  always_ff @(posedge ap_clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_index];
    end
  end

endmodule

`default_nettype wire

// File: source/param_reader.sv
//**********************************************************************
// Parameter reader.
// Serves the action core's parameter address/data stream from the
// parameter memory, with stop back-pressure on both sides.
//**********************************************************************

`timescale 1ns/1ps
`default_nettype none

module param_reader (
  input  logic                     ap_clk,
  input  logic                     reset,
  input  logic                     param_addr_valid,
  input  kernel_pkg::param_index_t param_addr,
  output logic                     param_addr_stop,
  output logic                     param_data_valid,
  output kernel_pkg::word_t        param_data,
  input  logic                     param_data_stop,
  output logic                     rd_en,
  output kernel_pkg::param_index_t rd_index,
  input  kernel_pkg::word_t        rd_data
);

  // A stalled output blocks new addresses; otherwise one can be taken in
  // the same cycle the current word leaves.
  assign param_addr_stop = param_data_valid && param_data_stop;

  assign rd_en    = param_addr_valid && !param_addr_stop;
  assign rd_index = param_addr;

  always_ff @(posedge ap_clk) begin
    if (reset) begin
      param_data_valid <= 1'b0;
    end else begin
      if (rd_en) begin
        param_data_valid <= 1'b1;
      end else if (!param_data_stop) begin
        param_data_valid <= 1'b0;
      end
    end
  end

  // The memory read register reloads only on an accepted address,
  // so it also holds a stopped word.
  assign param_data = rd_data;

  // Stopped data must not change or disappear.
  a_data_hold: assert property (@(posedge ap_clk) disable iff (reset)
    param_data_valid && param_data_stop |=> param_data_valid && $stable(param_data));

endmodule

`default_nettype wire

// File: source/kernel_ctrl_top.sv
//**********************************************************************
// Kernel host control block.
// Connects the AXI-Lite slave, the run/status registers, the parameter
// memory and the action core's parameter reader.
//**********************************************************************

`timescale 1ns/1ps
`default_nettype none

module kernel_ctrl_top (
  input  logic                     ap_clk,
  input  logic                     reset,
  input  kernel_pkg::axil_addr_t   aw_addr,
  input  logic                     aw_valid,
  output logic                     aw_ready,
  input  kernel_pkg::word_t        w_data,
  input  kernel_pkg::strb_t        w_strb,
  input  logic                     w_valid,
  output logic                     w_ready,
  output logic [1:0]               b_resp,
  output logic                     b_valid,
  input  logic                     b_ready,
  input  kernel_pkg::axil_addr_t   ar_addr,
  input  logic                     ar_valid,
  output logic                     ar_ready,
  output kernel_pkg::word_t        r_data,
  output logic [1:0]               r_resp,
  output logic                     r_valid,
  input  logic                     r_ready,
  output logic                     go_valid,
  input  logic                     go_stop,
  input  logic                     done_valid,
  output logic                     done_stop,
  input  logic                     param_addr_valid,
  input  kernel_pkg::param_index_t param_addr,
  output logic                     param_addr_stop,
  output logic                     param_data_valid,
  output kernel_pkg::word_t        param_data,
  input  logic                     param_data_stop,
  output logic                     interrupt
);

  // Register request bus.
  logic                     reg_req;
  logic                     reg_write_en;
  kernel_pkg::reg_addr_t    reg_addr;
  kernel_pkg::word_t        reg_wdata;
  kernel_pkg::strb_t        reg_wstrb;
  logic                     regs_ack;
  logic                     param_ack;
  kernel_pkg::word_t        regs_rdata;
  kernel_pkg::word_t        param_rdata;

  // Kernel read port of the parameter memory.
  logic                     rd_en;
  kernel_pkg::param_index_t rd_index;
  kernel_pkg::word_t        rd_data;

  ctrl_slave i_ctrl_slave (
    .ap_clk, .reset,
    .aw_addr, .aw_valid, .aw_ready,
    .w_data, .w_strb, .w_valid, .w_ready,
    .b_resp, .b_valid, .b_ready,
    .ar_addr, .ar_valid, .ar_ready,
    .r_data, .r_resp, .r_valid, .r_ready,
    .reg_req, .reg_write_en, .reg_addr, .reg_wdata, .reg_wstrb,
    .regs_ack, .param_ack, .regs_rdata, .param_rdata
  );

  ctrl_regs i_ctrl_regs (
    .ap_clk, .reset,
    .reg_req, .reg_write_en, .reg_addr, .reg_wdata, .reg_wstrb,
    .regs_ack, .regs_rdata,
    .go_valid, .go_stop, .done_valid, .done_stop,
    .interrupt
  );

  param_mem i_param_mem (
    .ap_clk,
    .reg_req, .reg_write_en, .reg_addr, .reg_wdata, .reg_wstrb,
    .param_ack, .param_rdata,
    .rd_en, .rd_index, .rd_data
  );

  param_reader i_param_reader (
    .ap_clk, .reset,
    .param_addr_valid, .param_addr, .param_addr_stop,
    .param_data_valid, .param_data, .param_data_stop,
    .rd_en, .rd_index, .rd_data
  );

endmodule

`default_nettype wire

// File: dv/kernel_ctrl_tb.sv
//**********************************************************************
// Kernel host control block testbench.
// Random AXI-Lite host traffic and an action-core stand-in, checked
// every cycle against a register and parameter memory model.
//**********************************************************************

`timescale 1ns/1ps
`default_nettype none

module kernel_ctrl_tb;

  localparam int N_RAND     = 300;
  localparam int N_RUNS     = 40;
  localparam int N_OPS      = (kernel_pkg::PARAM_WORDS - 4) + 3 * N_RAND + 9 * N_RUNS;
  localparam int MAX_CYCLES = N_OPS * 40;

  logic                     ap_clk = 1'b0;
  logic                     reset;
  kernel_pkg::axil_addr_t   aw_addr;
  logic                     aw_valid;
  logic                     aw_ready;
  kernel_pkg::word_t        w_data;
  kernel_pkg::strb_t        w_strb;
  logic                     w_valid;
  logic                     w_ready;
  logic [1:0]               b_resp;
  logic                     b_valid;
  logic                     b_ready;
  kernel_pkg::axil_addr_t   ar_addr;
  logic                     ar_valid;
  logic                     ar_ready;
  kernel_pkg::word_t        r_data;
  logic [1:0]               r_resp;
  logic                     r_valid;
  logic                     r_ready;
  logic                     go_valid;
  logic                     go_stop;
  logic                     done_valid;
  logic                     done_stop;
  logic                     param_addr_valid;
  kernel_pkg::param_index_t param_addr;
  logic                     param_addr_stop;
  logic                     param_data_valid;
  kernel_pkg::word_t        param_data;
  logic                     param_data_stop;
  logic                     interrupt;

  // Reference model state.
  kernel_pkg::word_t        shadow [kernel_pkg::PARAM_WORDS];
  kernel_pkg::word_t        stream_q [$];
  logic                     start_m, busy_m, done_m, gie_m, ier_m, isr_m, irq_m;
  logic                     hs_pending, req_stage, req_write;
  kernel_pkg::reg_addr_t    req_addr;
  kernel_pkg::word_t        req_data;
  kernel_pkg::strb_t        req_strb;
  kernel_pkg::word_t        exp_rdata;
  logic                     model_on, stream_on;
  int                       cycles = 0;

  kernel_ctrl_top i_kernel_ctrl_top (
    .ap_clk, .reset,
    .aw_addr, .aw_valid, .aw_ready,
    .w_data, .w_strb, .w_valid, .w_ready,
    .b_resp, .b_valid, .b_ready,
    .ar_addr, .ar_valid, .ar_ready,
    .r_data, .r_resp, .r_valid, .r_ready,
    .go_valid, .go_stop, .done_valid, .done_stop,
    .param_addr_valid, .param_addr, .param_addr_stop,
    .param_data_valid, .param_data, .param_data_stop,
    .interrupt
  );

  always #20 ap_clk = ~ap_clk;

  always @(posedge ap_clk) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      $display("Verification failed");
      $fatal(1, "Timeout after %0d cycles, the DUT stopped responding", MAX_CYCLES);
    end
  end

  task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch %s: got 0x%08h, expected 0x%08h", name, got, exp);
      $display("Verification failed");
      $fatal(1, "Stopped at the first error");
    end
  endtask

  // Inputs change and outputs are sampled 2 ns after the rising edge.
  task automatic tick();
    @(posedge ap_clk);
    #2;
  endtask

  task automatic axil_write(input kernel_pkg::reg_addr_t addr, input kernel_pkg::word_t data,
                            input kernel_pkg::strb_t strb);
    logic [3:0] upper;
    int         hold;
    upper    = $urandom;
    aw_addr  = {upper, addr};
    w_data   = data;
    w_strb   = strb;
    aw_valid = 1'b1;
    w_valid  = 1'b1;
    while (!aw_ready) tick();
    compare("w_ready", w_ready, 1'b1);
    req_write  = 1'b1;
    req_addr   = addr;
    req_data   = data;
    req_strb   = strb;
    hs_pending = 1'b1;
    for (int i = 1; i <= 3; i++) begin
      tick();
      aw_valid = 1'b0;
      w_valid  = 1'b0;
      compare("b_valid", b_valid, i == 3);
    end
    compare("b_resp", b_resp, kernel_pkg::RESP_OKAY);
    hold = $urandom_range(3, 0);
    repeat (hold) begin
      tick();
      compare("b_valid", b_valid, 1'b1);
    end
    b_ready = 1'b1;
    tick();
    b_ready = 1'b0;
    compare("b_valid", b_valid, 1'b0);
  endtask

  task automatic axil_read(input kernel_pkg::reg_addr_t addr, output kernel_pkg::word_t data);
    logic [3:0] upper;
    int         hold;
    upper    = $urandom;
    ar_addr  = {upper, addr};
    ar_valid = 1'b1;
    while (!ar_ready) tick();
    req_write  = 1'b0;
    req_addr   = addr;
    hs_pending = 1'b1;
    for (int i = 1; i <= 3; i++) begin
      tick();
      ar_valid = 1'b0;
      compare("r_valid", r_valid, i == 3);
    end
    compare("r_resp", r_resp, kernel_pkg::RESP_OKAY);
    compare("r_data", r_data, exp_rdata);
    data = r_data;
    hold = $urandom_range(3, 0);
    repeat (hold) begin
      tick();
      compare("r_valid", r_valid, 1'b1);
      compare("r_data", r_data, exp_rdata);
    end
    r_ready = 1'b1;
    tick();
    r_ready = 1'b0;
    compare("r_valid", r_valid, 1'b0);
  endtask

  // Effect of a host request on the edge that ends its request cycle.
  task automatic apply_request();
    kernel_pkg::param_index_t idx;
    logic                     idle_m;
    idx       = req_addr[kernel_pkg::REG_ADDR_W-1:2];
    idle_m    = !busy_m && !start_m;
    exp_rdata = '0;
    if (req_addr >= kernel_pkg::PARAM_BASE) begin
      exp_rdata = shadow[idx];
      for (int lane = 0; lane < kernel_pkg::STRB_W; lane++) begin
        if (req_write && req_strb[lane]) shadow[idx][8*lane +: 8] = req_data[8*lane +: 8];
      end
    end else if (!req_write) begin
      case (req_addr)
        kernel_pkg::REG_CTRL: begin
          exp_rdata[kernel_pkg::CTRL_START_BIT] = start_m;
          exp_rdata[kernel_pkg::CTRL_DONE_BIT]  = done_m;
          exp_rdata[kernel_pkg::CTRL_IDLE_BIT]  = idle_m;
          done_m = 1'b0;
        end
        kernel_pkg::REG_GIE: exp_rdata[0] = gie_m;
        kernel_pkg::REG_IER: exp_rdata[0] = ier_m;
        default: exp_rdata[0] = isr_m;
      endcase
    end else if (req_strb[0]) begin
      case (req_addr)
        kernel_pkg::REG_CTRL: if (req_data[kernel_pkg::CTRL_START_BIT] && idle_m) start_m = 1'b1;
        kernel_pkg::REG_GIE: gie_m = req_data[0];
        kernel_pkg::REG_IER: ier_m = req_data[0];
        default: if (req_data[0]) isr_m = !isr_m;
      endcase
    end
  endtask

  // One model step per cycle, 3 ns after the edge when all inputs are settled.
  task automatic model_cycle();
    logic stream_valid;
    logic go_x;
    logic done_x;
    stream_valid = stream_q.size() != 0;
    compare("go_valid", go_valid, start_m);
    compare("done_stop", done_stop, !busy_m);
    compare("interrupt", interrupt, irq_m);
    compare("param_data_valid", param_data_valid, stream_valid);
    compare("param_addr_stop", param_addr_stop, stream_valid && param_data_stop);
    if (stream_valid) begin
      compare("param_data", param_data, stream_q[0]);
      if (!param_data_stop) stream_q.delete(0);
    end
    // An address taken now sees the word before a host write on the same edge.
    if (param_addr_valid && !(stream_valid && param_data_stop)) begin
      stream_q.push_back(shadow[param_addr]);
    end
    go_x   = start_m && !go_stop;
    done_x = done_valid && busy_m;
    irq_m  = gie_m && ier_m && isr_m;
    if (req_stage) begin
      req_stage = 1'b0;
      apply_request();
    end
    if (hs_pending) begin
      hs_pending = 1'b0;
      req_stage  = 1'b1;
    end
    if (go_x) begin
      start_m = 1'b0;
      busy_m  = 1'b1;
    end
    // A finishing run wins over a done clear or ISR toggle.
    if (done_x) begin
      busy_m = 1'b0;
      done_m = 1'b1;
      isr_m  = 1'b1;
    end
  endtask

  always begin
    @(posedge ap_clk);
    #3;
    if (model_on) model_cycle();
  end

  // Action core stand-in for go and done.
  task automatic run_core();
    logic went;
    logic finished;
    int   countdown;
    went      = 1'b0;
    finished  = 1'b0;
    countdown = 0;
    forever begin
      tick();
      if (went) countdown = $urandom_range(24, 4);
      if (finished) done_valid = 1'b0;
      if (countdown > 0) begin
        countdown--;
        if (countdown == 0) done_valid = 1'b1;
      end
      go_stop  = $urandom_range(2, 0) == 0;
      went     = go_valid && !go_stop;
      finished = done_valid && !done_stop;
    end
  endtask

  // Action core stand-in for the parameter stream.
  task automatic run_stream();
    forever begin
      tick();
      param_data_stop  = $urandom_range(3, 0) == 0;
      param_addr_valid = stream_on && ($urandom_range(1, 0) == 1);
      param_addr       = $urandom_range(kernel_pkg::PARAM_WORDS - 1, 4);
    end
  endtask

  initial begin
    kernel_pkg::word_t        data;
    kernel_pkg::param_index_t idx;
    void'($urandom(32'h5d92));
    {aw_addr, aw_valid, w_data, w_strb, w_valid, b_ready} = '0;
    {ar_addr, ar_valid, r_ready, go_stop, done_valid} = '0;
    {param_addr_valid, param_addr, param_data_stop} = '0;
    {start_m, busy_m, done_m, gie_m, ier_m, isr_m, irq_m} = '0;
    {hs_pending, req_stage, req_write, model_on, stream_on} = '0;
    {req_addr, req_data, req_strb, exp_rdata} = '0;
    reset = 1'b1;
    repeat (8) @(posedge ap_clk);
    #2;
    reset = 1'b0;
    compare("aw_ready", aw_ready, 1'b0);
    compare("ar_ready", ar_ready, 1'b0);
    compare("b_valid", b_valid, 1'b0);
    compare("r_valid", r_valid, 1'b0);
    compare("done_stop", done_stop, 1'b1);
    model_on = 1'b1;
    fork
      run_core();
      run_stream();
    join_none

    // Fill every parameter word, then random strobed writes and readback.
    for (int i = 4; i < kernel_pkg::PARAM_WORDS; i++) begin
      idx = i;
      axil_write({idx, 2'b00}, $urandom, 4'hF);
    end
    stream_on = 1'b1;
    repeat (N_RAND) begin
      idx = $urandom_range(kernel_pkg::PARAM_WORDS - 1, 4);
      axil_write({idx, 2'b00}, $urandom, $urandom);
      axil_read({idx, 2'b00}, data);
      idx = $urandom_range(kernel_pkg::PARAM_WORDS - 1, 4);
      axil_read({idx, 2'b00}, data);
    end

    // Kernel runs, done clear on read and interrupt registers.
    for (int run = 0; run < N_RUNS; run++) begin
      axil_write(kernel_pkg::REG_GIE, $urandom, $urandom);
      axil_write(kernel_pkg::REG_IER, $urandom, $urandom);
      axil_read(kernel_pkg::REG_CTRL, data);
      axil_write(kernel_pkg::REG_CTRL, 32'h1 << kernel_pkg::CTRL_START_BIT, 4'hF);
      axil_write(kernel_pkg::REG_CTRL, 32'h1 << kernel_pkg::CTRL_START_BIT, 4'hF);
      if (run % 2 == 0) axil_read(kernel_pkg::REG_CTRL, data);
      while (busy_m || start_m) tick();
      axil_read(kernel_pkg::REG_CTRL, data);
      if (run % 2 == 1) compare("r_data", data[kernel_pkg::CTRL_DONE_BIT], 1'b1);
      axil_read(kernel_pkg::REG_CTRL, data);
      compare("r_data", data[kernel_pkg::CTRL_DONE_BIT], 1'b0);
      axil_write(kernel_pkg::REG_ISR, $urandom, 4'hF);
      axil_read(kernel_pkg::REG_ISR, data);
    end

    stream_on = 1'b0;
    while (stream_q.size() != 0) tick();
    repeat (4) tick();
    $display("Verification passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
source/kernel_pkg.sv
source/ctrl_slave.sv
source/ctrl_regs.sv
source/param_mem.sv
source/param_reader.sv
source/kernel_ctrl_top.sv
dv/kernel_ctrl_tb.sv

// File: Bender.yml
package:
  name: kernel_ctrl

sources:
  - files:
      - source/kernel_pkg.sv
      - source/ctrl_slave.sv
      - source/ctrl_regs.sv
      - source/param_mem.sv
      - source/param_reader.sv
      - source/kernel_ctrl_top.sv
  - target: simulation
    files:
      - dv/kernel_ctrl_tb.sv
